// ==== flist.f ====
source/selen_pkg.sv
source/ctrl_if.sv
source/cpu_ctrl.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_lsu.sv
source/cpu_exec.sv
dv/cpu_exec_chk.sv
dv/cpu_exec_tb.sv

// ==== Makefile ====
TOP := cpu_exec_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== dv/cpu_exec_tb.sv ====
// Testbench for the execute slice
// Random instructions, register and byte-memory model, compare tasks, timeout

`timescale 1ns/100ps

module cpu_exec_tb;

	localparam int N_INSTR = 3000;
	localparam int RST_CYCLES = 8;
	// Reset, all instructions and the last result, with a third to spare
	localparam int MAX_CYCLES = N_INSTR + N_INSTR / 3;
	// R_I order has no SLTU
	localparam logic [3:0] RI_OP [8] = '{4'd0, 4'd1, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd9};

	logic clk = 1'b0;
	logic rst;
	logic instr_valid;
	logic [6:0] opcode;
	logic [2:0] fnct;
	logic [1:0] fnct7;
	logic [selen_pkg::REG_AW-1:0] rd, rs1, rs2;
	logic [selen_pkg::XLEN-1:0] imm, pc;
	logic res_valid, wb_en, redirect, illegal;
	logic [selen_pkg::REG_AW-1:0] wb_addr;
	logic [selen_pkg::XLEN-1:0] wb_data, redirect_pc;

	// Expected output group of the instruction in flight
	logic exp_res_valid, exp_wb_en, exp_redirect, exp_illegal;
	logic [selen_pkg::REG_AW-1:0] exp_wb_addr;
	logic [selen_pkg::XLEN-1:0] exp_wb_data, exp_redirect_pc;

	logic [selen_pkg::XLEN-1:0] regs [32];
	logic [7:0] dmem [256];
	integer seed = 32'hb16f_5912;
	int cycles = 0;

	always #4 clk = ~clk;

	cpu_exec dut_i (.*);

	bind cpu_exec cpu_exec_chk chk_i (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.wb_en(wb_en),
		.redirect(redirect),
		.illegal(illegal)
	);

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic got_v);
		if (got_v !== exp_v) begin
			$display("MISMATCH %s: expected %h got %h", name, exp_v, got_v);
			abort_run();
		end
	endtask

	task automatic check_wb(
		input logic exp_en,
		input logic got_en,
		input logic [selen_pkg::REG_AW-1:0] exp_addr,
		input logic [selen_pkg::REG_AW-1:0] got_addr,
		input logic [selen_pkg::XLEN-1:0] exp_data,
		input logic [selen_pkg::XLEN-1:0] got_data
	);
		check_flag("wb_en", exp_en, got_en);
		if (got_addr !== exp_addr) begin
			$display("MISMATCH wb_addr: expected %h got %h", exp_addr, got_addr);
			abort_run();
		end
		if (got_data !== exp_data) begin
			$display("MISMATCH wb_data: expected %h got %h", exp_data, got_data);
			abort_run();
		end
	endtask

	task automatic check_redirect(
		input logic exp_r,
		input logic got_r,
		input logic [selen_pkg::XLEN-1:0] exp_pc,
		input logic [selen_pkg::XLEN-1:0] got_pc
	);
		check_flag("redirect", exp_r, got_r);
		if (got_pc !== exp_pc) begin
			$display("MISMATCH redirect_pc: expected %h got %h", exp_pc, got_pc);
			abort_run();
		end
	endtask

	function automatic int unsigned rnd(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [selen_pkg::XLEN-1:0] alu_ref(
		input logic [3:0] op,
		input logic [selen_pkg::XLEN-1:0] a,
		input logic [selen_pkg::XLEN-1:0] b
	);
		longint diff;
		diff = longint'($signed(a)) - longint'($signed(b));
		case (op)
			4'd0: return a + b;
			4'd1: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4'd2: return (a < b) ? 32'd1 : 32'd0;
			4'd3: return a & b;
			4'd4: return a | b;
			4'd5: return a ^ b;
			4'd6: return a << b[4:0];
			4'd7: return a >> b[4:0];
			4'd8: return a - b;
			4'd9: return $signed(a) >>> b[4:0];
			// Absolute difference of the signed values
			default: return (diff < 0) ? 32'(-diff) : 32'(diff);
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd2: return $signed(a) < $signed(b);
			3'd3: return a < b;
			3'd4: return $signed(a) >= $signed(b);
			default: return a >= b;
		endcase
	endfunction

	// Little-endian bytes, half and byte picked by the low address bits
	function automatic logic [selen_pkg::XLEN-1:0] load_value(input logic [2:0] f,
		input logic [7:0] ba);
		logic [15:0] hv;
		logic [7:0] bv;
		hv = {dmem[{ba[7:1], 1'b1}], dmem[{ba[7:1], 1'b0}]};
		bv = dmem[ba];
		case (f)
			3'd1: return {dmem[{ba[7:2], 2'd3}], dmem[{ba[7:2], 2'd2}],
				dmem[{ba[7:2], 2'd1}], dmem[{ba[7:2], 2'd0}]};
			3'd2: return {{16{hv[15]}}, hv};
			3'd3: return {16'b0, hv};
			3'd4: return {{24{bv[7]}}, bv};
			default: return {24'b0, bv};
		endcase
	endfunction

	task automatic store_value(input logic [2:0] f, input logic [7:0] ba,
		input logic [selen_pkg::XLEN-1:0] d);
		case (f)
			3'd1: begin
				for (int i = 0; i < 4; i++) begin
					dmem[{ba[7:2], 2'(i)}] = d[8*i +: 8];
				end
			end
			3'd2: begin
				dmem[{ba[7:1], 1'b0}] = d[7:0];
				dmem[{ba[7:1], 1'b1}] = d[15:8];
			end
			default: dmem[ba] = d[7:0];
		endcase
	endtask

	function automatic logic known_opcode(input logic [6:0] op);
		case (op)
			selen_pkg::OP_R, selen_pkg::OP_RI, selen_pkg::OP_LUI, selen_pkg::OP_AUIPC,
			selen_pkg::OP_BR, selen_pkg::OP_JAL, selen_pkg::OP_ST, selen_pkg::OP_LD: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic make_illegal();
		case (rnd(6))
			0: begin
				while (known_opcode(opcode)) begin
					opcode = 7'(rnd(128));
				end
			end
			1: begin
				opcode = selen_pkg::OP_R;
				fnct7 = 2'(2 + rnd(2));
			end
			2: begin
				opcode = selen_pkg::OP_R;
				fnct7 = 2'd1;
				fnct = 3'(3 + rnd(5));
			end
			3: begin
				opcode = selen_pkg::OP_BR;
				fnct = 3'(6 + rnd(2));
			end
			4: begin
				opcode = selen_pkg::OP_LD;
				fnct = 3'(6 + rnd(2));
			end
			default: begin
				opcode = selen_pkg::OP_ST;
				fnct = 3'(rnd(5));
				if (fnct != 3'd0) begin
					fnct = fnct + 3'd3;
				end
			end
		endcase
	endtask

	task automatic gen_instr();
		instr_valid = rnd(4) != 0;
		opcode = 7'(rnd(128));
		fnct = 3'(rnd(8));
		fnct7 = 2'(rnd(4));
		rd = 5'(rnd(8));
		rs1 = 5'(rnd(8));
		rs2 = 5'(rnd(8));
		imm = $random(seed);
		pc = $random(seed) & 32'hffff_fffc;
		if (instr_valid && rnd(20) == 0) begin
			make_illegal();
		end else if (instr_valid) begin
			case (rnd(14))
				0, 1: begin
					opcode = selen_pkg::OP_R;
					fnct7 = 2'(rnd(2));
					if (fnct7 != 2'd0) begin
						fnct = 3'(rnd(3));
					end
				end
				2, 3: opcode = selen_pkg::OP_RI;
				4: opcode = selen_pkg::OP_LUI;
				5: opcode = selen_pkg::OP_AUIPC;
				6, 7: begin
					opcode = selen_pkg::OP_BR;
					fnct = 3'(rnd(6));
				end
				8: opcode = selen_pkg::OP_JAL;
				9: begin
					opcode = selen_pkg::OP_LD;
					fnct = 3'd0;
				end
				// Memory accesses stay inside the first 64 bytes
				10, 11: begin
					opcode = selen_pkg::OP_ST;
					fnct = 3'(1 + rnd(3));
					rs1 = '0;
					imm = 32'(rnd(64));
				end
				default: begin
					opcode = selen_pkg::OP_LD;
					fnct = 3'(1 + rnd(5));
					rs1 = '0;
					imm = 32'(rnd(64));
				end
			endcase
		end
	endtask

	task automatic model_step();
		logic [selen_pkg::XLEN-1:0] a, b, ea, wval, rpc;
		logic wen, redir, bad;
		a = regs[rs1];
		b = regs[rs2];
		ea = a + imm;
		wval = '0;
		rpc = pc + imm;
		wen = 1'b0;
		redir = 1'b0;
		bad = 1'b0;
		if (instr_valid) begin
			case (opcode)
				selen_pkg::OP_R: begin
					wen = 1'b1;
					if (fnct7 == 2'd0) begin
						wval = alu_ref({1'b0, fnct}, a, b);
					end else if (fnct7 == 2'd1 && fnct <= 3'd2) begin
						wval = alu_ref(4'd8 + {1'b0, fnct}, a, b);
					end else begin
						bad = 1'b1;
					end
				end
				selen_pkg::OP_RI: begin
					wen = 1'b1;
					wval = alu_ref(RI_OP[fnct], a, imm);
				end
				selen_pkg::OP_LUI: begin
					wen = 1'b1;
					wval = imm;
				end
				selen_pkg::OP_AUIPC: begin
					wen = 1'b1;
					wval = pc + imm;
				end
				selen_pkg::OP_BR: begin
					bad = fnct > 3'd5;
					redir = branch_taken(fnct, a, b);
				end
				selen_pkg::OP_JAL: begin
					wen = 1'b1;
					wval = pc + 32'd4;
					redir = 1'b1;
				end
				selen_pkg::OP_LD: begin
					wen = 1'b1;
					if (fnct == 3'd0) begin
						wval = pc + 32'd4;
						redir = 1'b1;
						rpc = {ea[31:1], 1'b0};
					end else if (fnct <= 3'd5) begin
						wval = load_value(fnct, ea[7:0]);
					end else begin
						bad = 1'b1;
					end
				end
				selen_pkg::OP_ST: begin
					if (fnct >= 3'd1 && fnct <= 3'd3) begin
						store_value(fnct, ea[7:0], b);
					end else begin
						bad = 1'b1;
					end
				end
				default: bad = 1'b1;
			endcase
		end
		exp_res_valid = instr_valid;
		exp_illegal = bad;
		exp_wb_en = wen && !bad && rd != '0;
		exp_wb_addr = exp_wb_en ? rd : '0;
		exp_wb_data = exp_wb_en ? wval : '0;
		exp_redirect = redir && !bad;
		exp_redirect_pc = exp_redirect ? rpc : '0;
		if (exp_wb_en) begin
			regs[rd] = wval;
		end
	endtask

	task automatic compare_outputs();
		if (dut_i.chk_i.fail_count != 0) begin
			$display("The bound checker reported a failed assertion");
			abort_run();
		end
		check_flag("res_valid", exp_res_valid, res_valid);
		check_flag("illegal", exp_illegal, illegal);
		check_wb(exp_wb_en, wb_en, exp_wb_addr, wb_addr, exp_wb_data, wb_data);
		check_redirect(exp_redirect, redirect, exp_redirect_pc, redirect_pc);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = '0;
		end
		rst = 1'b1;
		instr_valid = 1'b0;
		opcode = '0;
		fnct = '0;
		fnct7 = '0;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		pc = '0;
		exp_res_valid = 1'b0;
		exp_wb_en = 1'b0;
		exp_redirect = 1'b0;
		exp_illegal = 1'b0;
		exp_wb_addr = '0;
		exp_wb_data = '0;
		exp_redirect_pc = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		// Each pass checks the previous result, then presents the next instruction
		for (int n = 0; n < N_INSTR; n++) begin
			compare_outputs();
			gen_instr();
			model_step();
			@(posedge clk);
			#1;
		end
		compare_outputs();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== dv/cpu_exec_chk.sv ====
// Bound assertions on the execute slice result outputs
// Flag consistency and reset values

`timescale 1ns/100ps

module cpu_exec_chk (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input logic wb_en,
	input logic redirect,
	input logic illegal
);

	// Count of failed assertions, seen by the testbench
	int fail_count = 0;

	// A write-back or redirect always comes with a result
	assert property (@(posedge clk) disable iff (rst) (wb_en || redirect) |-> res_valid)
		else begin
			fail_count++;
			$error("wb_en or redirect high without res_valid");
		end

	assert property (@(posedge clk) disable iff (rst) illegal |-> (!wb_en && !redirect))
		else begin
			fail_count++;
			$error("illegal instruction wrote back or redirected");
		end

	// Reset clears the result flags
	assert property (@(posedge clk) rst |=> !(res_valid || wb_en || redirect || illegal))
		else begin
			fail_count++;
			$error("result flags not low in the cycle after reset");
		end

endmodule

// ==== source/cpu_exec.sv ====
// Execute slice top level
// Write-back select and registered result outputs

`timescale 1ns/100ps

module cpu_exec (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [6:0] opcode,
	input logic [2:0] fnct,
	input logic [1:0] fnct7,
	input logic [selen_pkg::REG_AW-1:0] rd,
	input logic [selen_pkg::REG_AW-1:0] rs1,
	input logic [selen_pkg::REG_AW-1:0] rs2,
	input logic [selen_pkg::XLEN-1:0] imm,
	input logic [selen_pkg::XLEN-1:0] pc,
	output logic res_valid,
	output logic wb_en,
	output logic [selen_pkg::REG_AW-1:0] wb_addr,
	output logic [selen_pkg::XLEN-1:0] wb_data,
	output logic redirect,
	output logic [selen_pkg::XLEN-1:0] redirect_pc,
	output logic illegal
);

	logic [selen_pkg::XLEN-1:0] rs1_data, rs2_data;
	logic [selen_pkg::XLEN-1:0] alu_res, target, mem_rdata, wb_value;
	logic taken;
	logic reg_we;

	ctrl_if ctl_bus ();

	cpu_ctrl u_ctrl (
		.opcode(opcode),
		.fnct(fnct),
		.fnct7(fnct7),
		.instr_valid(instr_valid),
		.ctl_o(ctl_bus.dec)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.we(reg_we),
		.wa(rd),
		.wd(wb_value),
		.rd1(rs1_data),
		.rd2(rs2_data)
	);

	cpu_alu u_alu (
		.ctl_i(ctl_bus.dp),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.pc(pc),
		.result(alu_res),
		.taken(taken),
		.target(target)
	);

	cpu_lsu u_lsu (
		.clk(clk),
		.rst(rst),
		.ctl_i(ctl_bus.dp),
		.addr(alu_res),
		.wdata(rs2_data),
		.rdata(mem_rdata)
	);

	always_comb begin
		case (ctl_bus.ctl.wb_sel)
			selen_pkg::WB_MEM: wb_value = mem_rdata;
			selen_pkg::WB_LINK: wb_value = pc + 32'd4;
			selen_pkg::WB_IMM: wb_value = imm;
			default: wb_value = alu_res;
		endcase
	end

	// rd 0 never reports a write
	assign reg_we = ctl_bus.ctl.we_reg && rd != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			wb_en <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
			redirect <= 1'b0;
			redirect_pc <= '0;
			illegal <= 1'b0;
		end else begin
			res_valid <= ctl_bus.valid;
			wb_en <= reg_we;
			wb_addr <= reg_we ? rd : '0;
			wb_data <= reg_we ? wb_value : '0;
			redirect <= taken;
			redirect_pc <= taken ? target : '0;
			illegal <= ctl_bus.illegal;
		end
	end

endmodule

// ==== source/cpu_lsu.sv ====
// Data memory of 64 words
// Byte-lane stores, sign- or zero-extended loads

`timescale 1ns/100ps

module cpu_lsu (
	input logic clk,
	input logic rst,
	ctrl_if.dp ctl_i,
	input logic [selen_pkg::XLEN-1:0] addr,
	input logic [selen_pkg::XLEN-1:0] wdata,
	output logic [selen_pkg::XLEN-1:0] rdata
);

	localparam int LANES = selen_pkg::XLEN / 8;

	logic [selen_pkg::XLEN-1:0] mem [2**selen_pkg::DMEM_AW];
	logic [selen_pkg::DMEM_AW-1:0] idx;
	logic [LANES-1:0] be;
	logic [selen_pkg::XLEN-1:0] lane_data;
	logic [selen_pkg::XLEN-1:0] word;
	logic [15:0] half;
	logic [7:0] byte_v;

	assign idx = addr[selen_pkg::DMEM_AW+1:2];

	// Lane enables and replicated store data
	always_comb begin
		case (ctl_i.ctl.size)
			selen_pkg::SZ_HALF: begin
				be = addr[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{wdata[15:0]}};
			end
			selen_pkg::SZ_BYTE: begin
				be = 4'b0001 << addr[1:0];
				lane_data = {4{wdata[7:0]}};
			end
			default: begin
				be = '1;
				lane_data = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**selen_pkg::DMEM_AW; i++) begin
				mem[i] <= '0;
			end
		end else if (ctl_i.ctl.we_mem) begin
			for (int b = 0; b < LANES; b++) begin
				if (be[b]) begin
					mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
				end
			end
		end
	end

	assign word = mem[idx];
	assign half = addr[1] ? word[31:16] : word[15:0];
	assign byte_v = word[8*addr[1:0] +: 8];

	always_comb begin
		case (ctl_i.ctl.size)
			selen_pkg::SZ_HALF: rdata = ctl_i.ctl.ld_unsigned
				? {{(selen_pkg::XLEN-16){1'b0}}, half}
				: {{(selen_pkg::XLEN-16){half[15]}}, half};
			selen_pkg::SZ_BYTE: rdata = ctl_i.ctl.ld_unsigned
				? {{(selen_pkg::XLEN-8){1'b0}}, byte_v}
				: {{(selen_pkg::XLEN-8){byte_v[7]}}, byte_v};
			default: rdata = word;
		endcase
	end

endmodule

// ==== source/cpu_regfile.sv ====
// Register file, 32 entries, two read ports and one write port
// Register 0 reads as zero

`timescale 1ns/100ps

module cpu_regfile (
	input logic clk,
	input logic rst,
	input logic [selen_pkg::REG_AW-1:0] rs1,
	input logic [selen_pkg::REG_AW-1:0] rs2,
	input logic we,
	input logic [selen_pkg::REG_AW-1:0] wa,
	input logic [selen_pkg::XLEN-1:0] wd,
	output logic [selen_pkg::XLEN-1:0] rd1,
	output logic [selen_pkg::XLEN-1:0] rd2
);

	logic [selen_pkg::XLEN-1:0] regs [2**selen_pkg::REG_AW];

	// Write lands at the edge, so the next instruction reads it
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**selen_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/cpu_alu.sv ====
// ALU with operand selection
// Branch condition, taken flag and jump/branch target

`timescale 1ns/100ps

module cpu_alu (
	ctrl_if.dp ctl_i,
	input logic [selen_pkg::XLEN-1:0] rs1_data,
	input logic [selen_pkg::XLEN-1:0] rs2_data,
	input logic [selen_pkg::XLEN-1:0] imm,
	input logic [selen_pkg::XLEN-1:0] pc,
	output logic [selen_pkg::XLEN-1:0] result,
	output logic taken,
	output logic [selen_pkg::XLEN-1:0] target
);

	logic [selen_pkg::XLEN-1:0] op_a, op_b;
	logic [4:0] shamt;
	logic eq, lt, cond;

	assign op_a = ctl_i.ctl.a_pc ? pc : rs1_data;
	assign op_b = ctl_i.ctl.b_imm ? imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctl_i.ctl.alu_op)
			selen_pkg::ALU_ADD: result = op_a + op_b;
			selen_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			selen_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
			selen_pkg::ALU_AND: result = op_a & op_b;
			selen_pkg::ALU_OR: result = op_a | op_b;
			selen_pkg::ALU_XOR: result = op_a ^ op_b;
			selen_pkg::ALU_SLL: result = op_a << shamt;
			selen_pkg::ALU_SRL: result = op_a >> shamt;
			selen_pkg::ALU_SUB: result = op_a - op_b;
			selen_pkg::ALU_SRA: result = $signed(op_a) >>> shamt;
			// Absolute difference, signed operands
			selen_pkg::ALU_AM: result = ($signed(op_a) > $signed(op_b)) ? op_a - op_b : op_b - op_a;
			default: result = '0;
		endcase
	end

	// Branch compare always on the register values
	assign eq = rs1_data == rs2_data;
	assign lt = ctl_i.ctl.brn_unsigned ? (rs1_data < rs2_data)
		: ($signed(rs1_data) < $signed(rs2_data));

	always_comb begin
		case (ctl_i.ctl.brn)
			selen_pkg::BR_EQ: cond = eq;
			selen_pkg::BR_NE: cond = !eq;
			selen_pkg::BR_LT: cond = lt;
			default: cond = !lt;
		endcase
	end

	assign taken = ctl_i.ctl.is_jump || (ctl_i.ctl.is_branch && cond);
	// JALR drops bit 0 of rs1+imm
	assign target = ctl_i.ctl.jump_reg ? {result[selen_pkg::XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== source/cpu_ctrl.sv ====
// Control decoder
// Opcode and function fields to datapath controls and the illegal flag

`timescale 1ns/100ps

module cpu_ctrl (
	input logic [6:0] opcode,
	input logic [2:0] fnct,
	input logic [1:0] fnct7,
	input logic instr_valid,
	ctrl_if.dec ctl_o
);

	logic b_imm, a_pc;
	selen_pkg::wb_sel_e wb_sel;
	logic we_reg, we_mem;
	selen_pkg::size_e size;
	logic ld_unsigned;
	logic is_jump, jump_reg;
	logic ill_op;

	selen_pkg::alu_op_e alu_op;
	logic is_branch;
	selen_pkg::brn_e brn;
	logic brn_unsigned;
	logic ill_fn;

	logic ok;
	selen_pkg::ctrl_t dec_ctl;

	// Selects, enables, access size
	always_comb begin
		b_imm = 1'b0;
		a_pc = 1'b0;
		wb_sel = selen_pkg::WB_ALU;
		we_reg = 1'b0;
		we_mem = 1'b0;
		size = selen_pkg::SZ_FULL;
		ld_unsigned = 1'b0;
		is_jump = 1'b0;
		jump_reg = 1'b0;
		ill_op = 1'b0;
		case (opcode)
			selen_pkg::OP_R: begin
				we_reg = 1'b1;
			end
			selen_pkg::OP_RI: begin
				b_imm = 1'b1;
				we_reg = 1'b1;
			end
			selen_pkg::OP_LUI: begin
				wb_sel = selen_pkg::WB_IMM;
				we_reg = 1'b1;
			end
			selen_pkg::OP_AUIPC: begin
				a_pc = 1'b1;
				b_imm = 1'b1;
				we_reg = 1'b1;
			end
			selen_pkg::OP_BR: begin
				we_reg = 1'b0;
			end
			selen_pkg::OP_JAL: begin
				wb_sel = selen_pkg::WB_LINK;
				we_reg = 1'b1;
				is_jump = 1'b1;
			end
			selen_pkg::OP_LD: begin
				b_imm = 1'b1;
				we_reg = 1'b1;
				wb_sel = selen_pkg::WB_MEM;
				case (fnct)
					// JALR, target from rs1+imm
					3'b000: begin
						wb_sel = selen_pkg::WB_LINK;
						is_jump = 1'b1;
						jump_reg = 1'b1;
					end
					3'b001: size = selen_pkg::SZ_FULL;
					3'b010: size = selen_pkg::SZ_HALF;
					3'b011: begin
						size = selen_pkg::SZ_HALF;
						ld_unsigned = 1'b1;
					end
					3'b100: size = selen_pkg::SZ_BYTE;
					3'b101: begin
						size = selen_pkg::SZ_BYTE;
						ld_unsigned = 1'b1;
					end
					default: ill_op = 1'b1;
				endcase
			end
			selen_pkg::OP_ST: begin
				b_imm = 1'b1;
				we_mem = 1'b1;
				case (fnct)
					3'b001: size = selen_pkg::SZ_FULL;
					3'b010: size = selen_pkg::SZ_HALF;
					3'b011: size = selen_pkg::SZ_BYTE;
					default: ill_op = 1'b1;
				endcase
			end
			default: ill_op = 1'b1;
		endcase
	end

	// ALU operation and branch kind
	always_comb begin
		alu_op = selen_pkg::ALU_ADD;
		is_branch = 1'b0;
		brn = selen_pkg::BR_EQ;
		brn_unsigned = 1'b0;
		ill_fn = 1'b0;
		case (opcode)
			selen_pkg::OP_R: begin
				if (fnct7 == 2'b00) begin
					alu_op = selen_pkg::alu_op_e'({1'b0, fnct});
				end else if (fnct7 == 2'b01) begin
					case (fnct)
						3'b000: alu_op = selen_pkg::ALU_SUB;
						3'b001: alu_op = selen_pkg::ALU_SRA;
						3'b010: alu_op = selen_pkg::ALU_AM;
						default: ill_fn = 1'b1;
					endcase
				end else begin
					ill_fn = 1'b1;
				end
			end
			selen_pkg::OP_RI: begin
				case (fnct)
					3'b000: alu_op = selen_pkg::ALU_ADD;
					3'b001: alu_op = selen_pkg::ALU_SLT;
					3'b010: alu_op = selen_pkg::ALU_AND;
					3'b011: alu_op = selen_pkg::ALU_OR;
					3'b100: alu_op = selen_pkg::ALU_XOR;
					3'b101: alu_op = selen_pkg::ALU_SLL;
					3'b110: alu_op = selen_pkg::ALU_SRL;
					default: alu_op = selen_pkg::ALU_SRA;
				endcase
			end
			selen_pkg::OP_BR: begin
				alu_op = selen_pkg::ALU_SUB;
				is_branch = 1'b1;
				case (fnct)
					3'b000: brn = selen_pkg::BR_EQ;
					3'b001: brn = selen_pkg::BR_NE;
					3'b010: brn = selen_pkg::BR_LT;
					3'b011: begin
						brn = selen_pkg::BR_LT;
						brn_unsigned = 1'b1;
					end
					3'b100: brn = selen_pkg::BR_GE;
					3'b101: begin
						brn = selen_pkg::BR_GE;
						brn_unsigned = 1'b1;
					end
					default: ill_fn = 1'b1;
				endcase
			end
			default: alu_op = selen_pkg::ALU_ADD;
		endcase
	end

	// Nothing commits unless valid and legal
	assign ok = instr_valid && !ill_op && !ill_fn;

	always_comb begin
		dec_ctl.alu_op = alu_op;
		dec_ctl.b_imm = b_imm;
		dec_ctl.a_pc = a_pc;
		dec_ctl.wb_sel = wb_sel;
		dec_ctl.we_reg = we_reg && ok;
		dec_ctl.we_mem = we_mem && ok;
		dec_ctl.size = size;
		dec_ctl.ld_unsigned = ld_unsigned;
		dec_ctl.is_branch = is_branch && ok;
		dec_ctl.brn = brn;
		dec_ctl.brn_unsigned = brn_unsigned;
		dec_ctl.is_jump = is_jump && ok;
		dec_ctl.jump_reg = jump_reg;
	end

	assign ctl_o.valid = instr_valid;
	assign ctl_o.ctl = dec_ctl;
	assign ctl_o.illegal = instr_valid && (ill_op || ill_fn);

endmodule

// ==== source/ctrl_if.sv ====
// Decoded control bundle from the decoder to the datapath blocks

`timescale 1ns/100ps

interface ctrl_if;

	logic valid;
	selen_pkg::ctrl_t ctl;
	logic illegal;

	modport dec (
		output valid,
		output ctl,
		output illegal
	);

	modport dp (
		input valid,
		input ctl,
		input illegal
	);

endinterface

// ==== source/selen_pkg.sv ====
// Shared definitions for the execute slice
// Sizes, opcode values, ALU/size/branch/write-back encodings, control struct

package selen_pkg;

	// Sizes
	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam int DMEM_AW = 6;

	// Opcodes
	localparam logic [6:0] OP_R = 7'b0000011;
	localparam logic [6:0] OP_RI = 7'b1000011;
	localparam logic [6:0] OP_LUI = 7'b0100011;
	localparam logic [6:0] OP_AUIPC = 7'b0110011;
	localparam logic [6:0] OP_BR = 7'b0010011;
	localparam logic [6:0] OP_JAL = 7'b0001011;
	localparam logic [6:0] OP_ST = 7'b0001111;
	// Loads, plus JALR at fnct 000
	localparam logic [6:0] OP_LD = 7'b0000111;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SLT = 4'd1,
		ALU_SLTU = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_SUB = 4'd8,
		ALU_SRA = 4'd9,
		ALU_AM = 4'd10
	} alu_op_e;

	typedef enum logic [1:0] {
		SZ_FULL = 2'd0,
		SZ_HALF = 2'd1,
		SZ_BYTE = 2'd2
	} size_e;

	typedef enum logic [1:0] {
		BR_EQ = 2'd0,
		BR_NE = 2'd1,
		BR_LT = 2'd2,
		BR_GE = 2'd3
	} brn_e;

	// Write-back source, LINK is pc+4
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_LINK = 2'd2,
		WB_IMM = 2'd3
	} wb_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic b_imm;
		logic a_pc;
		wb_sel_e wb_sel;
		logic we_reg;
		logic we_mem;
		size_e size;
		logic ld_unsigned;
		logic is_branch;
		brn_e brn;
		logic brn_unsigned;
		logic is_jump;
		logic jump_reg;
	} ctrl_t;

endpackage
